// ==== hw/panel_pkg.sv ====
// panel package: geometry of the 32x16 matrix, rgb565 pixel format and framebuffer addressing
`default_nettype none

package panel_pkg;

	// panel scanned as two halves of 8 rows
	localparam int panel_cols = 32;
	localparam int half_rows  = 8;
	localparam int num_planes = 4;

	// word address is row * 32 + col, rows 0 to 15
	typedef logic [$clog2(panel_cols * half_rows * 2)-1:0] fb_addr_t;

	// rgb565, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} pixel_t;

	// scan counters
	typedef logic [$clog2(panel_cols)-1:0] col_t;
	typedef logic [$clog2(half_rows)-1:0]  row_t;
	typedef logic [$clog2(num_planes)-1:0] plane_t;

	// plane p shows red bit p+1, green bit p+2, blue bit p+1

endpackage

`default_nettype wire

// ==== hw/link_pkg.sv ====
// host link package: command bytes, frame lengths and the display enable register layout
`default_nettype none

package link_pkg;

	// lead bytes
	localparam logic [7:0] cmd_pixel = 8'h50;
	localparam logic [7:0] cmd_enable = 8'h45;

	// argument bytes after the lead byte
	// pixel: addr hi, addr lo, data hi, data lo
	localparam int pixel_arg_bytes  = 4;
	localparam int enable_arg_bytes = 1;

	// bit 0 red, bit 1 green, bit 2 blue
	typedef struct packed {
		logic       unused;
		logic [3:0] plane_en;
		logic [2:0] rgb_en;
	} enable_t;

	localparam enable_t enable_reset = '{unused: 1'b0, plane_en: 4'hf, rgb_en: 3'h7};

endpackage

`default_nettype wire

// ==== hw/fb_port_if.sv ====
// framebuffer port: request/grant handshake with registered read data for one client
`timescale 1ns/1ps
`default_nettype none

interface fb_port_if;
	import panel_pkg::*;

	// client side, held until gnt
	logic     req;
	logic     we;
	fb_addr_t addr;
	pixel_t   wdata;
	// arbiter side
	// gnt is a single cycle, rdata/rvalid follow one cycle later
	logic     gnt;
	pixel_t   rdata;
	logic     rvalid;

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

`default_nettype wire

// ==== hw/uart_rx.sv ====
// uart receiver: 8n1 with mid-bit sampling, one byte strobe per good frame
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 20
) (
	input  logic       clk_root,
	input  logic       rst,
	input  logic       rxd,
	output logic       byte_valid,
	output logic [7:0] byte_data
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;

	always_ff @(posedge clk_root) begin
		if (rst) begin
			// line idles high
			rx_meta    <= 1'b1;
			rx_sync    <= 1'b1;
			state      <= st_idle;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			// two-flop synchroniser
			rx_meta    <= rxd;
			rx_sync    <= rx_meta;
			byte_valid <= 1'b0;
			clk_cnt    <= clk_cnt + 1'b1;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= st_start;
				end
				st_start: begin
					// half a bit in, start must still be low
					if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? st_idle : st_data;
					end
				end
				st_data: begin
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
				end
				default: begin
					// bad stop bit drops the frame
					if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
						byte_valid <= rx_sync;
						state      <= st_idle;
					end
				end
			endcase
		end
	end

	// lsb first, byte_data only moves with a good stop bit
	always_ff @(posedge clk_root) begin
		if (state == st_data && clk_cnt == CNT_W'(CLKS_PER_BIT - 1))
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (state == st_stop && clk_cnt == CNT_W'(CLKS_PER_BIT - 1) && rx_sync)
			byte_data <= shift_reg;
	end

endmodule

`default_nettype wire

// ==== hw/cmd_parser.sv ====
// command parser: decodes host "P" and "E" frames into framebuffer writes and display enables
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
	input  logic              clk_root,
	input  logic              rst,
	input  logic              byte_valid,
	input  logic [7:0]        byte_data,
	fb_port_if.client         fb,
	output link_pkg::enable_t enables
);
	import panel_pkg::*;
	import link_pkg::*;

	typedef enum logic [1:0] {st_idle, st_pixel, st_enable} state_t;

	state_t     state;
	logic [2:0] arg_cnt;
	// assembly regs, kept apart from fb.addr/wdata while a write waits
	logic       addr_hi;
	logic [7:0] addr_lo;
	logic [7:0] data_hi;

	// write port only
	assign fb.we = fb.req;

	always_ff @(posedge clk_root) begin
		if (rst) begin
			state   <= st_idle;
			arg_cnt <= '0;
			fb.req  <= 1'b0;
			enables <= enable_reset;
		end else begin
			// drop req once the arbiter takes it
			if (fb.gnt)
				fb.req <= 1'b0;
			if (byte_valid) begin
				case (state)
					st_idle: begin
						arg_cnt <= '0;
						// unknown lead bytes are ignored
						if (byte_data == cmd_pixel)
							state <= st_pixel;
						else if (byte_data == cmd_enable)
							state <= st_enable;
					end
					st_pixel: begin
						arg_cnt <= arg_cnt + 1'b1;
						if (arg_cnt == 3'(pixel_arg_bytes - 1)) begin
							fb.req <= 1'b1;
							state  <= st_idle;
						end
					end
					default: begin
						arg_cnt <= arg_cnt + 1'b1;
						if (arg_cnt == 3'(enable_arg_bytes - 1)) begin
							enables <= enable_t'(byte_data);
							state   <= st_idle;
						end
					end
				endcase
			end
		end
	end

	// payload capture, address taken modulo 512
	always_ff @(posedge clk_root) begin
		if (byte_valid && state == st_pixel) begin
			case (arg_cnt[1:0])
				2'd0: addr_hi <= byte_data[0];
				2'd1: addr_lo <= byte_data;
				2'd2: data_hi <= byte_data;
				default: begin
					fb.addr  <= fb_addr_t'({addr_hi, addr_lo});
					fb.wdata <= pixel_t'({data_hi, byte_data});
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/fb_arbiter.sv ====
// framebuffer arbiter: fixed priority between fetch and host clients over one single-port ram
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
	input  logic       clk_root,
	fb_port_if.arbiter fetch,
	fb_port_if.arbiter host
);
	import panel_pkg::*;

	localparam int FB_WORDS = 2 ** $bits(fb_addr_t);

	pixel_t   mem [0:FB_WORDS-1];
	fb_addr_t mem_addr;
	pixel_t   mem_wdata;
	logic     mem_we;
	logic     mem_rd;
	pixel_t   rdata_q;
	logic     fetch_rvalid;
	logic     host_rvalid;

	// fetch always wins, host only when fetch is idle
	assign fetch.gnt = fetch.req;
	assign host.gnt  = host.req && !fetch.req;

	// single port, steer by grant
	assign mem_addr  = fetch.gnt ? fetch.addr : host.addr;
	assign mem_wdata = fetch.gnt ? fetch.wdata : host.wdata;
	assign mem_we    = (fetch.gnt && fetch.we) || (host.gnt && host.we);
	assign mem_rd    = (fetch.gnt && !fetch.we) || (host.gnt && !host.we);

	// write lands at the grant edge
	always_ff @(posedge clk_root) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		if (mem_rd)
			rdata_q <= mem[mem_addr];
	end

	// read strobes one cycle after gnt
	always_ff @(posedge clk_root) begin
		fetch_rvalid <= fetch.gnt && !fetch.we;
		host_rvalid  <= host.gnt && !host.we;
	end

	// shared read register, valid per port
	assign fetch.rdata  = rdata_q;
	assign fetch.rvalid = fetch_rvalid;
	assign host.rdata   = rdata_q;
	assign host.rvalid  = host_rvalid;

endmodule

`default_nettype wire

// ==== hw/matrix_scan.sv ====
// matrix scan: shifts columns, latches rows and times the weighted output-enable window per plane
`timescale 1ns/1ps
`default_nettype none

module matrix_scan #(
	parameter int OE_BASE = 4
) (
	input  logic              clk_root,
	input  logic              rst,
	input  logic              col_ready,
	input  logic [2:0]        rgb_top_in,
	input  logic [2:0]        rgb_bot_in,
	output logic              col_req,
	output panel_pkg::row_t   row,
	output panel_pkg::col_t   col,
	output panel_pkg::plane_t plane,
	output logic              pixel_clk,
	output logic              latch,
	output logic              oe_n,
	output panel_pkg::row_t   row_addr,
	output logic [2:0]        rgb_top,
	output logic [2:0]        rgb_bot
);
	import panel_pkg::*;

	// longest window is the top plane
	localparam int OE_MAX = OE_BASE << (num_planes - 1);
	localparam int OE_W   = $clog2(OE_MAX + 1);

	typedef enum logic [1:0] {st_shift, st_clock, st_latch, st_display} state_t;

	state_t          state;
	logic            waiting;
	logic [OE_W-1:0] oe_cnt;

	// one-cycle request at the start of each column
	assign col_req = (state == st_shift) && !waiting;

	always_ff @(posedge clk_root) begin
		if (rst) begin
			state     <= st_shift;
			waiting   <= 1'b0;
			col       <= '0;
			row       <= '0;
			plane     <= '0;
			pixel_clk <= 1'b0;
			latch     <= 1'b0;
			oe_n      <= 1'b1;
			row_addr  <= '0;
			oe_cnt    <= '0;
			rgb_top   <= '0;
			rgb_bot   <= '0;
		end else begin
			// clock edge one cycle behind the data
			pixel_clk <= (state == st_clock);
			latch     <= 1'b0;
			case (state)
				st_shift: begin
					if (!waiting) begin
						waiting <= 1'b1;
					end else if (col_ready) begin
						waiting <= 1'b0;
						rgb_top <= rgb_top_in;
						rgb_bot <= rgb_bot_in;
						state   <= st_clock;
					end
				end
				st_clock: begin
					col   <= col + 1'b1;
					state <= (col == col_t'(panel_cols - 1)) ? st_latch : st_shift;
				end
				st_latch: begin
					// displayed row only moves here
					latch    <= 1'b1;
					row_addr <= row;
					oe_cnt   <= OE_W'(OE_BASE << plane);
					state    <= st_display;
				end
				default: begin
					if (oe_cnt != '0) begin
						oe_n   <= 1'b0;
						oe_cnt <= oe_cnt - 1'b1;
					end else begin
						// window done, next plane then next row
						oe_n  <= 1'b1;
						plane <= plane + 1'b1;
						if (plane == plane_t'(num_planes - 1))
							row <= row + 1'b1;
						state <= st_shift;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/pixel_fetch.sv ====
// pixel fetch: reads top and bottom pixels per column and slices out the current plane bits
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch (
	input  logic              clk_root,
	input  logic              rst,
	input  logic              col_req,
	input  panel_pkg::row_t   row,
	input  panel_pkg::col_t   col,
	input  panel_pkg::plane_t plane,
	input  link_pkg::enable_t enables,
	fb_port_if.client         fb,
	output logic              col_ready,
	output logic [2:0]        rgb_top,
	output logic [2:0]        rgb_bot
);
	import panel_pkg::*;
	import link_pkg::*;

	typedef enum logic [1:0] {st_idle, st_top, st_bot, st_wait} state_t;

	state_t state;
	pixel_t pix_top;
	pixel_t pix_bot;

	// plane bits of one pixel, masked by colour and plane enables
	function automatic logic [2:0] plane_bits(pixel_t px, plane_t p, enable_t en);
		logic [2:0] b;
		b[0] = px.red[p + 1];
		b[1] = px.green[p + 2];
		b[2] = px.blue[p + 1];
		return b & en.rgb_en & {3{en.plane_en[p]}};
	endfunction

	// read-only client
	assign fb.we    = 1'b0;
	assign fb.wdata = '0;

	always_ff @(posedge clk_root) begin
		if (rst) begin
			state     <= st_idle;
			fb.req    <= 1'b0;
			col_ready <= 1'b0;
		end else begin
			col_ready <= 1'b0;
			case (state)
				st_idle: begin
					if (col_req) begin
						fb.req <= 1'b1;
						state  <= st_top;
					end
				end
				// req stays up across both reads
				st_top: if (fb.gnt) state <= st_bot;
				st_bot: begin
					if (fb.gnt) begin
						fb.req <= 1'b0;
						state  <= st_wait;
					end
				end
				default: begin
					if (fb.rvalid) begin
						col_ready <= 1'b1;
						state     <= st_idle;
					end
				end
			endcase
		end
	end

	// top at row*32+col, bottom 256 words on
	always_ff @(posedge clk_root) begin
		if (state == st_idle && col_req)
			fb.addr <= fb_addr_t'({1'b0, row, col});
		if (state == st_top && fb.gnt)
			fb.addr <= fb_addr_t'({1'b1, row, col});
		// top data comes back while the bottom read is in flight
		if (state == st_bot && fb.rvalid)
			pix_top <= fb.rdata;
		if (state == st_wait && fb.rvalid)
			pix_bot <= fb.rdata;
	end

	assign rgb_top = plane_bits(pix_top, plane, enables);
	assign rgb_bot = plane_bits(pix_bot, plane, enables);

endmodule

`default_nettype wire

// ==== hw/led_panel_top.sv ====
// led panel top: uart command input, shared framebuffer and hub75 scan outputs
`timescale 1ns/1ps
`default_nettype none

module led_panel_top #(
	parameter int CLKS_PER_BIT = 20,
	parameter int OE_BASE      = 4
) (
	input  logic       clk_root,
	input  logic       rst,
	input  logic       uart_rxd,
	output logic       pixel_clk,
	output logic       latch,
	output logic       oe_n,
	output logic [2:0] row_addr,
	output logic [2:0] rgb_top,
	output logic [2:0] rgb_bot
);
	import panel_pkg::*;
	import link_pkg::*;

	logic       byte_valid;
	logic [7:0] byte_data;
	enable_t    enables;
	// scan to fetch handshake
	logic       col_req;
	logic       col_ready;
	row_t       row;
	col_t       col;
	plane_t     plane;
	logic [2:0] fetch_top;
	logic [2:0] fetch_bot;

	fb_port_if fetch_port ();
	fb_port_if host_port ();

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.clk_root, .rst, .rxd(uart_rxd), .byte_valid, .byte_data
	);

	cmd_parser u_parser (
		.clk_root, .rst, .byte_valid, .byte_data, .fb(host_port), .enables
	);

	// fetch port has priority over host writes
	fb_arbiter u_arb (.clk_root, .fetch(fetch_port), .host(host_port));

	pixel_fetch u_fetch (
		.clk_root, .rst, .col_req, .row, .col, .plane, .enables, .fb(fetch_port),
		.col_ready, .rgb_top(fetch_top), .rgb_bot(fetch_bot)
	);

	matrix_scan #(.OE_BASE(OE_BASE)) u_scan (
		.clk_root, .rst, .col_ready, .rgb_top_in(fetch_top), .rgb_bot_in(fetch_bot),
		.col_req, .row, .col, .plane, .pixel_clk, .latch, .oe_n, .row_addr,
		.rgb_top, .rgb_bot
	);

endmodule

`default_nettype wire

// ==== verif/led_panel_tb.sv ====
// led panel testbench: uart host driver, framebuffer model and hub75 scan monitor with checks
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb;

	localparam int clks_per_bit = 20;
	localparam int oe_base      = 4;
	localparam logic [7:0] lead_pixel  = 8'h50;
	localparam logic [7:0] lead_enable = 8'h45;
	// pixel frames in the back-pressure burst
	localparam int burst_frames = 24;

	// worst case per column: request, two reads, ready, clock, plus margin
	localparam int col_worst    = 12;
	localparam int frame_cycles = 8 * (4 * (32 * col_worst + 4) + oe_base * 15);
	// every byte sent, plus the idle gap before each checked frame
	localparam int uart_bytes   = 512 * 5 + 2 * 2 + burst_frames * 5;
	localparam int uart_cycles  = uart_bytes * 10 * clks_per_bit + 3 * 2 * clks_per_bit;
	// reset plus up to two frames per check (partial wait, then the checked frame)
	localparam int cycle_limit  = uart_cycles + 7 * frame_cycles + 100;

	logic       clk_root;
	logic       rst;
	logic       uart_rxd;
	logic       pixel_clk;
	logic       latch;
	logic       oe_n;
	logic [2:0] row_addr;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bot;

	// host-side copy of the display state
	logic [15:0] fb_model [0:511];
	logic [7:0]  en_model;

	// monitor state
	logic        first_col;
	logic        check_req;
	logic        checking;
	logic        window_open;
	logic [2:0]  mon_row;
	logic [1:0]  mon_plane;
	int          col_cnt;
	int          oe_low;
	int          frames_checked;
	int          check_count;
	int          error_count;
	int          cycles;
	string       test_name;

	led_panel_top #(.CLKS_PER_BIT(clks_per_bit), .OE_BASE(oe_base)) uut (
		.clk_root, .rst, .uart_rxd, .pixel_clk, .latch, .oe_n, .row_addr,
		.rgb_top, .rgb_bot
	);

	initial begin
		clk_root = 1'b0;
		forever #10 clk_root = ~clk_root;
	end

	// plane p: red bit p+1, green bit p+2, blue bit p+1 of rgb565
	function automatic logic [2:0] expected_bits(input logic [15:0] px, input logic [1:0] p,
			input logic [7:0] en);
		logic [2:0] b;
		b[0] = px[12 + p];
		b[1] = px[7 + p];
		b[2] = px[1 + p];
		return b & en[2:0] & {3{en[3 + p]}};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	// 8n1, lsb first
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int         i;
		frame = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk_root);
			uart_rxd <= frame[i];
			repeat (clks_per_bit - 1) @(posedge clk_root);
		end
	endtask

	// address is wrapped to 512 words by the parser
	task automatic send_pixel(input logic [15:0] addr, input logic [15:0] data);
		send_byte(lead_pixel);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		send_byte(data[15:8]);
		send_byte(data[7:0]);
		fb_model[addr[8:0]] = data;
	endtask

	task automatic send_enable(input logic [7:0] en);
		send_byte(lead_enable);
		send_byte(en);
		en_model = en;
	endtask

	// idle gap, then one whole frame from row 0 plane 0 under check
	task automatic run_checked_frame();
		int target;
		repeat (2 * clks_per_bit) @(posedge clk_root);
		target = frames_checked + 1;
		check_req <= 1'b1;
		while (frames_checked < target)
			@(posedge clk_root);
		check_req <= 1'b0;
	endtask

	always @(posedge clk_root) begin : monitor
		logic [8:0] addr;
		logic       check_now;
		if (rst) begin
			first_col      <= 1'b1;
			checking       <= 1'b0;
			window_open    <= 1'b0;
			mon_row        <= '0;
			mon_plane      <= '0;
			col_cnt        <= 0;
			oe_low         <= 0;
			frames_checked <= 0;
		end else begin
			// quiet outputs until the first column is clocked
			if (first_col) begin
				check_value("reset oe_n", 1, 32'(oe_n));
				check_value("reset latch", 0, 32'(latch));
				check_value("reset row_addr", 0, 32'(row_addr));
				if (pixel_clk)
					first_col <= 1'b0;
			end
			if (!window_open)
				check_value("oe_n outside window", 1, 32'(oe_n));
			if (pixel_clk) begin
				check_value("oe_n during pixel_clk", 1, 32'(oe_n));
				// a checked frame starts on column 0 of row 0 plane 0
				check_now = checking ||
					(check_req && col_cnt == 0 && mon_row == 3'd0 && mon_plane == 2'd0);
				if (check_now) begin
					checking <= 1'b1;
					addr = 9'(mon_row * 32 + col_cnt);
					check_value("rgb_top", 32'(expected_bits(fb_model[addr], mon_plane, en_model)),
						32'(rgb_top));
					addr = addr + 9'd256;
					check_value("rgb_bot", 32'(expected_bits(fb_model[addr], mon_plane, en_model)),
						32'(rgb_bot));
				end
				col_cnt <= col_cnt + 1;
			end
			if (latch) begin
				check_value("oe_n during latch", 1, 32'(oe_n));
				check_value("pixel_clk pulses per latch", 32, col_cnt);
				check_value("row_addr after latch", 32'(mon_row), 32'(row_addr));
				col_cnt     <= 0;
				oe_low      <= 0;
				window_open <= 1'b1;
			end
			if (window_open && !oe_n)
				oe_low <= oe_low + 1;
			// window ends when oe_n rises again
			if (window_open && (pixel_clk || (oe_n && oe_low != 0))) begin
				check_value("oe window length", oe_base << mon_plane, oe_low);
				window_open <= 1'b0;
				mon_plane   <= mon_plane + 1'b1;
				if (mon_plane == 2'd3)
					mon_row <= mon_row + 1'b1;
				if (checking && mon_plane == 2'd3 && mon_row == 3'd7) begin
					checking       <= 1'b0;
					frames_checked <= frames_checked + 1;
				end
			end
		end
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk_root);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("tests failed");
		$finish;
	end

	initial begin : main
		int i;
		void'($urandom(11));
		check_count = 0;
		error_count = 0;
		test_name   = "reset_state";
		// reset value of the enable register
		en_model    = 8'h7f;
		rst       <= 1'b1;
		uart_rxd  <= 1'b1;
		check_req <= 1'b0;
		repeat (5) @(posedge clk_root);
		rst <= 1'b0;
		@(posedge clk_root);
		while (first_col)
			@(posedge clk_root);

		// every word, with junk above the 9 address bits
		test_name = "pixel_data";
		for (i = 0; i < 512; i++)
			send_pixel({7'($urandom()), 9'(i)}, 16'($urandom()));
		run_checked_frame();

		test_name = "enables";
		send_enable(8'($urandom()) & 8'h7f);
		run_checked_frame();

		// back to back writes while the fetcher holds priority
		test_name = "back_pressure";
		send_enable(8'h7f);
		for (i = 0; i < burst_frames; i++)
			send_pixel(16'($urandom()), 16'($urandom()));
		run_checked_frame();

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== led_panel.f ====
hw/panel_pkg.sv
hw/link_pkg.sv
hw/fb_port_if.sv
hw/uart_rx.sv
hw/cmd_parser.sv
hw/fb_arbiter.sv
hw/matrix_scan.sv
hw/pixel_fetch.sv
hw/led_panel_top.sv
verif/led_panel_tb.sv
